// ==== Bender.yml ====
package:
  name: hazard_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/hzd_pkg.sv
      - source/hzd_fwd_if.sv
      - source/hzd_stage_if.sv
      - source/fwd_unit.sv
      - source/stall_flush_ctrl.sv
      - source/flush_track.sv
      - source/hazard_unit.sv
  - target: test
    files:
      - testbench/tb_hazard_unit.sv

// ==== flist.f ====
+incdir+include
source/hzd_pkg.sv
source/hzd_fwd_if.sv
source/hzd_stage_if.sv
source/fwd_unit.sv
source/stall_flush_ctrl.sv
source/flush_track.sv
source/hazard_unit.sv
testbench/tb_hazard_unit.sv

// ==== include/hzd_params.svh ====
`ifndef HZD_PARAMS_SVH
`define HZD_PARAMS_SVH

// Field widths, fixed by the instruction set
`define HZD_PC_W      12  // Instruction address
`define HZD_REG_W     5   // Register index
`define HZD_OPC_W     7   // Major opcode
`define HZD_WBSEL_W   3   // Writeback source select
`define HZD_IMMSEL_W  3   // Immediate format select

// RISC-V major opcodes
`define OPC_LOAD      7'b0000011
`define OPC_STORE     7'b0100011
`define OPC_BRANCH    7'b1100011
`define OPC_JALR      7'b1100111
`define OPC_OP        7'b0110011  // Register-register ALU ops

// Writeback select code for load data
`define WBSEL_LOAD    3'b001

// Immediate select code for I-type
// rs2 field holds immediate bits here
`define IMMSEL_I      3'b000

`endif

// ==== source/flush_track.sv ====
`timescale 1ns/100ps

module flush_track (
    input  logic           clk,
    input  logic           nrst,
    input  logic           wb_wr_en,
    // Stage clock enables
    output logic           if_clk_en,
    output logic           id_clk_en,
    output logic           exe_clk_en,
    output logic           mem_clk_en,
    output logic           wb_clk_en,
    output logic           rf_clk_en,       // Register file write
    // Qualified load forwards into EXE
    output logic           fw_wb_to_exe_a,
    output logic           fw_wb_to_exe_b,
    hzd_stage_if.track_dst stage,
    hzd_fwd_if.track_dst   fwd
);

    logic id_prev_flush;
    logic exe_prev_flush;
    logic mem_prev_flush;
    logic wb_prev_flush;
    logic front_hold;

    // A flushed slot walks one stage per cycle until it leaves WB
    always_ff @(posedge clk) begin
        if (!nrst) begin
            id_prev_flush  <= 1'b0;
            exe_prev_flush <= 1'b0;
            mem_prev_flush <= 1'b0;
            wb_prev_flush  <= 1'b0;
        end else begin
            // Interrupt entry refills ID, so nothing stale to follow
            id_prev_flush  <= (stage.id_flush || stage.loop_jump) && !stage.isr_pipe_flush;
            exe_prev_flush <= id_prev_flush ? 1'b1 : stage.exe_flush;
            mem_prev_flush <= exe_prev_flush ? 1'b1 : stage.mem_flush;
            wb_prev_flush  <= mem_prev_flush;  // WB itself never flushes
        end
    end

    assign stage.id_prev_flush  = id_prev_flush;
    assign stage.exe_prev_flush = exe_prev_flush;
    assign stage.mem_prev_flush = mem_prev_flush;
    assign stage.wb_prev_flush  = wb_prev_flush;

    // Loop jump freezes fetch and decode, unless an interrupt is taken
    assign front_hold = stage.loop_jump && !stage.isr_pipe_flush;

    assign if_clk_en  = !(stage.id_stall || front_hold);
    assign id_clk_en  = !(stage.id_stall || front_hold);
    // NOPs never clock EXE
    assign exe_clk_en = !(stage.exe_stall || id_prev_flush || stage.is_nop);
    assign mem_clk_en = !(stage.mem_flush || exe_prev_flush);
    assign wb_clk_en  = !mem_prev_flush;
    assign rf_clk_en  = wb_wr_en && !wb_prev_flush;

    // Bubble in WB carries no valid load data
    assign fw_wb_to_exe_a = fwd.raw_wb_to_exe_a && !wb_prev_flush;
    assign fw_wb_to_exe_b = fwd.raw_wb_to_exe_b && !wb_prev_flush;

endmodule

// ==== source/fwd_unit.sv ====
`timescale 1ns/100ps

`include "hzd_params.svh"

module fwd_unit (
    // Source registers
    input  hzd_pkg::reg_idx_t id_rs_a,
    input  hzd_pkg::reg_idx_t id_rs_b,
    input  hzd_pkg::reg_idx_t exe_rs_a,
    input  hzd_pkg::reg_idx_t exe_rs_b,
    // Destination registers
    input  hzd_pkg::reg_idx_t exe_rd,
    input  hzd_pkg::reg_idx_t mem_rd,
    input  hzd_pkg::reg_idx_t wb_rd,
    input  logic              exe_wr_en,
    input  logic              mem_wr_en,
    input  logic              wb_wr_en,
    // ID operand usage
    input  logic              id_sel_opa,
    input  logic              id_sel_opb,
    input  logic              id_is_stype,
    input  logic              id_sel_opbr,    // Register-based branch/jump target
    input  hzd_pkg::imm_sel_t id_imm_select,
    input  hzd_pkg::opcode_t  id_opcode,
    // EXE operand usage
    input  logic              exe_comp_use_a, // Compressed form reads rsA
    input  logic              exe_comp_use_b, // Compressed form reads rsB
    input  logic              exe_is_comp,
    input  hzd_pkg::opcode_t  exe_opcode,
    // Writeback source per stage
    input  hzd_pkg::wb_sel_t  exe_sel_data,
    input  hzd_pkg::wb_sel_t  mem_sel_data,
    input  hzd_pkg::wb_sel_t  wb_sel_data,
    // Forward selects into ID
    output logic              fw_exe_to_id_a,
    output logic              fw_exe_to_id_b,
    output logic              fw_mem_to_id_a,
    output logic              fw_mem_to_id_b,
    output logic              fw_wb_to_id_a,
    output logic              fw_wb_to_id_b,
    hzd_fwd_if.fwd_src        fwd
);
    import hzd_pkg::*;

    logic exe_load;
    logic mem_load;
    logic wb_load;
    logic id_use_a;
    logic id_use_b;
    logic exe_alu_b;
    logic exe_use_a;
    logic exe_use_b;
    logic exe_m_a;
    logic exe_m_b;

    // Live write to a nonzero rd that matches the source
    function automatic logic wr_match(input logic we, input reg_idx_t rd, input reg_idx_t rs);
        return we && (rd == rs) && (rd != '0);
    endfunction

    function automatic logic is_load(input wb_sel_t sel);
        return sel == `WBSEL_LOAD;
    endfunction

    assign exe_load = is_load(exe_sel_data);  // Data not ready until MEM ends
    assign mem_load = is_load(mem_sel_data);
    assign wb_load  = is_load(wb_sel_data);

    // ID operand reads
    assign id_use_a = id_sel_opa;
    // rsB also needed by stores and branch compares
    // I-type reuses the rs2 field as immediate bits
    assign id_use_b = (id_sel_opb && (id_imm_select != `IMMSEL_I))
                    || (id_is_stype && (id_opcode == `OPC_STORE))
                    || (id_sel_opbr && (id_opcode == `OPC_BRANCH));

    // EXE operand reads
    assign exe_alu_b = (exe_opcode == `OPC_OP) || (exe_opcode == `OPC_STORE)
                     || (exe_opcode == `OPC_BRANCH);
    assign exe_use_a = exe_is_comp ? exe_comp_use_a : 1'b1;
    assign exe_use_b = exe_is_comp ? exe_comp_use_b : exe_alu_b;

    assign exe_m_a = wr_match(exe_wr_en, exe_rd, id_rs_a);
    assign exe_m_b = wr_match(exe_wr_en, exe_rd, id_rs_b);

    // EXE has priority, loads in EXE cannot forward yet
    assign fw_exe_to_id_a = exe_m_a && id_use_a && !exe_load;
    assign fw_exe_to_id_b = exe_m_b && id_use_b && !exe_load;

    // MEM next, load data still in flight
    assign fw_mem_to_id_a = wr_match(mem_wr_en, mem_rd, id_rs_a) && id_use_a
                          && !fw_exe_to_id_a && !mem_load;
    assign fw_mem_to_id_b = wr_match(mem_wr_en, mem_rd, id_rs_b) && id_use_b
                          && !fw_exe_to_id_b && !mem_load;

    // WB last, any result type
    assign fw_wb_to_id_a = wr_match(wb_wr_en, wb_rd, id_rs_a) && id_use_a
                         && !fw_exe_to_id_a && !fw_mem_to_id_a;
    assign fw_wb_to_id_b = wr_match(wb_wr_en, wb_rd, id_rs_b) && id_use_b
                         && !fw_exe_to_id_b && !fw_mem_to_id_b;

    // JALR resolves its target in ID, so a load one stage ahead stalls it
    assign fwd.hzd_exe_to_id_a = exe_m_a && exe_load && (id_opcode == `OPC_JALR);

    // Load-use against EXE
    assign fwd.hzd_mem_to_exe_a = wr_match(mem_wr_en, mem_rd, exe_rs_a) && mem_load && exe_use_a;
    assign fwd.hzd_mem_to_exe_b = wr_match(mem_wr_en, mem_rd, exe_rs_b) && mem_load && exe_use_b;

    // Load data reaching WB while the consumer waits in EXE
    assign fwd.raw_wb_to_exe_a = wr_match(wb_wr_en, wb_rd, exe_rs_a) && wb_load;
    assign fwd.raw_wb_to_exe_b = wr_match(wb_wr_en, wb_rd, exe_rs_b) && wb_load;

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/100ps

module hazard_unit (
    input  logic              clk,
    input  logic              nrst,
    // Fetch and decode
    input  hzd_pkg::pc_t      if_pc,
    input  hzd_pkg::pc_t      id_pc,
    input  logic              is_jump,
    input  logic              is_nop,
    // Flush and busy sources
    input  logic              isr_pc_flush,
    input  logic              isr_pipe_flush,
    input  logic              branch_flush,
    input  logic              jump_flush,
    input  logic              mul_stall,
    input  logic              div_running,
    // Register indices
    input  hzd_pkg::reg_idx_t id_rs_a,
    input  hzd_pkg::reg_idx_t id_rs_b,
    input  hzd_pkg::reg_idx_t exe_rs_a,
    input  hzd_pkg::reg_idx_t exe_rs_b,
    input  hzd_pkg::reg_idx_t exe_rd,
    input  hzd_pkg::reg_idx_t mem_rd,
    input  hzd_pkg::reg_idx_t wb_rd,
    input  logic              exe_wr_en,
    input  logic              mem_wr_en,
    input  logic              wb_wr_en,
    // Operand usage and decode fields
    input  logic              id_sel_opa,
    input  logic              id_sel_opb,
    input  logic              id_is_stype,
    input  logic              id_sel_opbr,
    input  hzd_pkg::imm_sel_t id_imm_select,
    input  hzd_pkg::opcode_t  id_opcode,
    input  hzd_pkg::opcode_t  exe_opcode,
    input  logic              exe_comp_use_a,
    input  logic              exe_comp_use_b,
    input  logic              exe_is_comp,
    input  hzd_pkg::wb_sel_t  exe_sel_data,
    input  hzd_pkg::wb_sel_t  mem_sel_data,
    input  hzd_pkg::wb_sel_t  wb_sel_data,
    // Stalls, flushes and enables
    output logic              if_stall,
    output logic              id_stall,
    output logic              exe_stall,
    output logic              mem_stall,
    output logic              wb_stall,
    output logic              if_flush,
    output logic              id_flush,
    output logic              exe_flush,
    output logic              mem_flush,
    output logic              wb_flush,
    output logic              if_clk_en,
    output logic              id_clk_en,
    output logic              exe_clk_en,
    output logic              mem_clk_en,
    output logic              wb_clk_en,
    output logic              rf_clk_en,
    // Forward selects
    output logic              fw_exe_to_id_a,
    output logic              fw_exe_to_id_b,
    output logic              fw_mem_to_id_a,
    output logic              fw_mem_to_id_b,
    output logic              fw_wb_to_id_a,
    output logic              fw_wb_to_id_b,
    output logic              fw_wb_to_exe_a,
    output logic              fw_wb_to_exe_b,
    output logic              load_hazard
);

    hzd_fwd_if   fwd_bus ();    // Decode compare to control and tracker
    hzd_stage_if stage_bus ();  // Control to tracker and back

    // Port names match the top level, only the buses need naming
    fwd_unit i_fwd_unit (.fwd(fwd_bus), .*);

    stall_flush_ctrl i_stall_flush_ctrl (.fwd(fwd_bus), .stage(stage_bus), .*);

    flush_track i_flush_track (.stage(stage_bus), .fwd(fwd_bus), .*);

endmodule

// ==== source/hzd_fwd_if.sv ====
`timescale 1ns/100ps

// Hazard flags and raw writeback forwards out of the decode compare
interface hzd_fwd_if;

    logic hzd_exe_to_id_a;   // EXE load feeds a JALR base in ID
    logic hzd_mem_to_exe_a;  // MEM load feeds EXE rsA
    logic hzd_mem_to_exe_b;  // MEM load feeds EXE rsB
    logic raw_wb_to_exe_a;   // WB load matches EXE rsA, not yet qualified
    logic raw_wb_to_exe_b;   // Same for rsB

    // Register-match decode side
    modport fwd_src (
        output hzd_exe_to_id_a,
        output hzd_mem_to_exe_a,
        output hzd_mem_to_exe_b,
        output raw_wb_to_exe_a,
        output raw_wb_to_exe_b
    );

    // Stall and flush generation only needs the hazards
    modport ctrl_dst (
        input hzd_exe_to_id_a,
        input hzd_mem_to_exe_a,
        input hzd_mem_to_exe_b
    );

    // Flush tracker qualifies the WB forwards
    modport track_dst (
        input raw_wb_to_exe_a,
        input raw_wb_to_exe_b
    );

endinterface

// ==== source/hzd_pkg.sv ====
package hzd_pkg;

`include "hzd_params.svh"

    // Instruction address in IF and ID
    typedef logic [`HZD_PC_W-1:0] pc_t;

    // Source or destination register index
    // Index 0 is x0, never a real write
    typedef logic [`HZD_REG_W-1:0] reg_idx_t;

    // Major opcode, bits [6:0] of the instruction
    typedef logic [`HZD_OPC_W-1:0] opcode_t;

    // Which result goes to the register file
    // Loads are marked by a single code
    typedef logic [`HZD_WBSEL_W-1:0] wb_sel_t;

    // Immediate format chosen by the decoder
    typedef logic [`HZD_IMMSEL_W-1:0] imm_sel_t;

endpackage

// ==== source/hzd_stage_if.sv ====
`timescale 1ns/100ps

// Per-stage flush and stall levels between control and the flush tracker
interface hzd_stage_if;

    // From stall/flush control
    logic id_flush;
    logic exe_flush;
    logic mem_flush;
    logic loop_jump;       // Self-looping jump sitting in ID
    logic isr_pipe_flush;  // Interrupt entry, overrides loop hold
    logic exe_stall;
    logic id_stall;        // Also the IF stall, both are identical
    logic is_nop;          // NOP headed for EXE

    // From the tracker, one bit per stage holding a flushed slot
    logic id_prev_flush;   // Flushed from ID last cycle, now in EXE
    logic exe_prev_flush;
    logic mem_prev_flush;
    logic wb_prev_flush;

    modport ctrl_src (
        output id_flush, exe_flush, mem_flush,
        output loop_jump, isr_pipe_flush,
        output exe_stall, id_stall, is_nop,
        input  mem_prev_flush  // Blocks back-to-back MEM flushes
    );

    modport track_dst (
        input  id_flush, exe_flush, mem_flush,
        input  loop_jump, isr_pipe_flush,
        input  exe_stall, id_stall, is_nop,
        output id_prev_flush, exe_prev_flush, mem_prev_flush, wb_prev_flush
    );

endinterface

// ==== source/stall_flush_ctrl.sv ====
`timescale 1ns/100ps

module stall_flush_ctrl (
    input  hzd_pkg::pc_t  if_pc,
    input  hzd_pkg::pc_t  id_pc,
    input  logic          is_jump,         // Jump decoded in ID
    input  logic          is_nop,          // NOP decoded in ID
    input  logic          id_sel_opbr,     // Register-based target, JALR
    // Interrupt controller
    input  logic          isr_pc_flush,
    input  logic          isr_pipe_flush,
    // Branch prediction outcome
    input  logic          branch_flush,
    input  logic          jump_flush,
    // Multi-cycle units
    input  logic          mul_stall,
    input  logic          div_running,
    // Stalls
    output logic          if_stall,        // PC and instruction memory
    output logic          id_stall,        // IF/ID register
    output logic          exe_stall,       // ID/EXE register
    output logic          mem_stall,
    output logic          wb_stall,
    // Flushes, active-high clears of the pipeline registers
    output logic          if_flush,
    output logic          id_flush,
    output logic          exe_flush,
    output logic          mem_flush,
    output logic          wb_flush,
    output logic          load_hazard,
    hzd_fwd_if.ctrl_dst   fwd,
    hzd_stage_if.ctrl_src stage
);

    logic jalr_hazard;
    logic unit_busy;
    logic loop_jump;

    // One-cycle hold of IF and ID for a load feeding JALR
    assign jalr_hazard = fwd.hzd_exe_to_id_a;

    // Load-use, masked when MEM already holds a bubble
    assign load_hazard = (fwd.hzd_mem_to_exe_a || fwd.hzd_mem_to_exe_b)
                       && !stage.mem_prev_flush;

    assign unit_busy = div_running || mul_stall;  // Multiplier or divider not done

    // Stalls
    assign if_stall  = load_hazard || jalr_hazard || unit_busy;
    assign id_stall  = load_hazard || jalr_hazard || unit_busy;
    assign exe_stall = load_hazard || unit_busy;  // EXE load drains on a JALR hazard
    assign mem_stall = 1'b0;
    assign wb_stall  = 1'b0;

    // Flushes
    assign if_flush  = isr_pc_flush;
    assign id_flush  = isr_pipe_flush || jump_flush || branch_flush;
    assign exe_flush = jalr_hazard || branch_flush || is_nop;  // Bubble behind the JALR
    assign mem_flush = load_hazard || unit_busy;
    assign wb_flush  = 1'b0;

    // Jump to its own address, held in place until an interrupt
    // JAL only, JALR targets are not known from the PC compare
    assign loop_jump = (if_pc == id_pc) && is_jump && !id_sel_opbr && !id_stall;

    // Levels handed to the flush tracker
    assign stage.id_flush       = id_flush;
    assign stage.exe_flush      = exe_flush;
    assign stage.mem_flush      = mem_flush;
    assign stage.loop_jump      = loop_jump;
    assign stage.isr_pipe_flush = isr_pipe_flush;
    assign stage.exe_stall      = exe_stall;
    assign stage.id_stall       = id_stall;
    assign stage.is_nop         = is_nop;

endmodule

// ==== testbench/hazard_tests.txt ====
# name cycles if_pc id_pc flags(hex) id_rs_a id_rs_b exe_rs_a exe_rs_b exe_rd mem_rd wb_rd
#   id_opcode exe_opcode imm_sel exe_sel mem_sel wb_sel expected(bin: stalls flushes enables fwd load_hazard)
reset_idle 4 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
fwd_priority 1 000 000 01f00 05 05 00 00 05 05 05 33 00 1 0 0 0 0000000000111111110000000
fwd_rd_zero 1 000 000 01f00 00 00 00 00 00 00 00 33 00 1 0 0 0 0000000000111111000000000
fwd_exe_load 1 000 000 01f00 05 05 00 00 05 05 05 33 00 1 1 0 0 0000000000111111001100000
drain_1 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
load_use 1 000 000 00200 00 00 07 00 00 07 00 00 00 0 0 1 0 1110000010000010000000001
drain_2 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
load_use_hold 2 000 000 00200 00 00 07 00 00 07 00 00 00 0 0 1 0 0000000000111100000000000
drain_3 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
jalr_load 1 000 000 00900 03 00 00 00 03 00 00 67 00 0 1 0 0 1100000100001110000000000
drain_4 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
div_busy 1 000 000 00080 00 00 00 00 00 00 00 00 00 0 0 0 0 1110000010000010000000000
drain_5 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
isr_pc 1 000 000 00004 00 00 00 00 00 00 00 00 00 0 0 0 0 0000010000111110000000000
branch 2 000 000 00010 00 00 00 00 00 00 00 00 00 0 0 0 0 0000001100110010000000000
drain_6 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
nop 1 000 000 00002 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000100110110000000000
drain_7 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
loop_jump 1 010 010 00001 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000001110000000000
drain_8 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
loop_jump_isr 1 010 010 00009 00 00 00 00 00 00 00 00 00 0 0 0 0 0000001000111110000000000
drain_9 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000
wb_write 1 000 000 00400 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111111000000000
jump_flush 1 000 000 00020 00 00 00 00 00 00 00 00 00 0 0 0 0 0000001000111110000000000
wb_load_flushed 4 000 000 00400 00 00 09 09 00 00 09 00 00 0 0 0 1 0000000000111110000000000
wb_load_fwd 1 000 000 00400 00 00 09 09 00 00 09 00 00 0 0 0 1 0000000000111111000000110
drain_end 5 000 000 00000 00 00 00 00 00 00 00 00 00 0 0 0 0 0000000000111110000000000

// ==== testbench/tb_hazard_unit.sv ====
`timescale 1ns/100ps

module tb_hazard_unit;

    localparam int MAX_VEC = 64;

    // Idle response with every enable high but the register file write
    localparam logic [24:0] IDLE_EXP = 25'b00000_00000_111110_00000000_0;

    logic        clk;
    logic        nrst;
    logic [11:0] if_pc;
    logic [11:0] id_pc;
    logic        is_jump, is_nop, isr_pc_flush, isr_pipe_flush;
    logic        branch_flush, jump_flush, mul_stall, div_running;
    logic [4:0]  id_rs_a, id_rs_b, exe_rs_a, exe_rs_b, exe_rd, mem_rd, wb_rd;
    logic        exe_wr_en, mem_wr_en, wb_wr_en;
    logic        id_sel_opa, id_sel_opb, id_is_stype, id_sel_opbr;
    logic [2:0]  id_imm_select;
    logic [6:0]  id_opcode, exe_opcode;
    logic        exe_comp_use_a, exe_comp_use_b, exe_is_comp;
    logic [2:0]  exe_sel_data, mem_sel_data, wb_sel_data;
    logic        if_stall, id_stall, exe_stall, mem_stall, wb_stall;
    logic        if_flush, id_flush, exe_flush, mem_flush, wb_flush;
    logic        if_clk_en, id_clk_en, exe_clk_en, mem_clk_en, wb_clk_en, rf_clk_en;
    logic        fw_exe_to_id_a, fw_exe_to_id_b, fw_mem_to_id_a, fw_mem_to_id_b;
    logic        fw_wb_to_id_a, fw_wb_to_id_b, fw_wb_to_exe_a, fw_wb_to_exe_b;
    logic        load_hazard;
    logic [24:0] actual;                  // All outputs packed in file order

    // Vector storage with one entry per file line
    string            vec_name [MAX_VEC];
    int               vec_cyc [MAX_VEC];
    logic [11:0]      vec_if_pc [MAX_VEC];
    logic [11:0]      vec_id_pc [MAX_VEC];
    logic [19:0]      vec_flags [MAX_VEC];
    logic [0:6][4:0]  vec_reg [MAX_VEC];  // ID a/b, EXE a/b, EXE/MEM/WB rd
    logic [6:0]       vec_id_opc [MAX_VEC];
    logic [6:0]       vec_exe_opc [MAX_VEC];
    logic [0:3][2:0]  vec_sel [MAX_VEC];  // imm select, EXE/MEM/WB writeback select
    logic [24:0]      vec_exp [MAX_VEC];
    int               num_vec;
    int               pass_count;
    int               fail_count;
    int               cycle_count;
    int               cycle_limit;

    hazard_unit i_dut (.*);

    assign actual = {if_stall, id_stall, exe_stall, mem_stall, wb_stall,
                     if_flush, id_flush, exe_flush, mem_flush, wb_flush,
                     if_clk_en, id_clk_en, exe_clk_en, mem_clk_en, wb_clk_en, rf_clk_en,
                     fw_exe_to_id_a, fw_exe_to_id_b, fw_mem_to_id_a, fw_mem_to_id_b,
                     fw_wb_to_id_a, fw_wb_to_id_b, fw_wb_to_exe_a, fw_wb_to_exe_b,
                     load_hazard};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Run limit from the total of held cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, test sequence did not complete", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // Whole file read up front, so the limit is known before reset ends
    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        string nm;
        int    cyc;
        logic [11:0] p0, p1;
        logic [19:0] fl;
        logic [4:0]  r0, r1, r2, r3, r4, r5, r6;
        logic [6:0]  o0, o1;
        logic [2:0]  s0, s1, s2, s3;
        logic [24:0] ex;
        fd = $fopen("testbench/hazard_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file");
            fail_count++;
        end else begin
            num_vec = 0;
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#")
                    continue;  // Comment or blank
                n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %b",
                            nm, cyc, p0, p1, fl, r0, r1, r2, r3, r4, r5, r6,
                            o0, o1, s0, s1, s2, s3, ex);
                if (n != 19) begin
                    $display("Malformed vector line: %s", line);
                    fail_count++;
                    continue;
                end
                vec_name[num_vec]    = nm;
                vec_cyc[num_vec]     = cyc;
                vec_if_pc[num_vec]   = p0;
                vec_id_pc[num_vec]   = p1;
                vec_flags[num_vec]   = fl;
                vec_reg[num_vec]     = {r0, r1, r2, r3, r4, r5, r6};
                vec_id_opc[num_vec]  = o0;
                vec_exe_opc[num_vec] = o1;
                vec_sel[num_vec]     = {s0, s1, s2, s3};
                vec_exp[num_vec]     = ex;
                cycle_limit += cyc;
                num_vec++;
            end
            $fclose(fd);
        end
    endtask

    // Drive on the edge, hold, sample mid-cycle on the last held cycle
    task automatic apply_vector(input int idx);
        logic [19:0] f;
        f = vec_flags[idx];
        @(posedge clk);
        if_pc          <= vec_if_pc[idx];
        id_pc          <= vec_id_pc[idx];
        is_jump        <= f[0];
        is_nop         <= f[1];
        isr_pc_flush   <= f[2];
        isr_pipe_flush <= f[3];
        branch_flush   <= f[4];
        jump_flush     <= f[5];
        mul_stall      <= f[6];
        div_running    <= f[7];
        exe_wr_en      <= f[8];
        mem_wr_en      <= f[9];
        wb_wr_en       <= f[10];
        id_sel_opa     <= f[11];
        id_sel_opb     <= f[12];
        id_is_stype    <= f[13];
        id_sel_opbr    <= f[14];
        exe_comp_use_a <= f[15];
        exe_comp_use_b <= f[16];
        exe_is_comp    <= f[17];
        id_rs_a        <= vec_reg[idx][0];
        id_rs_b        <= vec_reg[idx][1];
        exe_rs_a       <= vec_reg[idx][2];
        exe_rs_b       <= vec_reg[idx][3];
        exe_rd         <= vec_reg[idx][4];
        mem_rd         <= vec_reg[idx][5];
        wb_rd          <= vec_reg[idx][6];
        id_opcode      <= vec_id_opc[idx];
        exe_opcode     <= vec_exe_opc[idx];
        id_imm_select  <= vec_sel[idx][0];
        exe_sel_data   <= vec_sel[idx][1];
        mem_sel_data   <= vec_sel[idx][2];
        wb_sel_data    <= vec_sel[idx][3];
        repeat (vec_cyc[idx] - 1) @(posedge clk);
        @(negedge clk);
        check_outputs(vec_name[idx], vec_exp[idx]);
    endtask

    task automatic check_outputs(input string name, input logic [24:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            fail_count++;
        end else begin
            $display("PASS %s", name);
            pass_count++;
        end
    endtask

    initial begin
        // Idle levels on every input from time zero
        nrst = 1'b0;
        {if_pc, id_pc} = '0;
        {is_jump, is_nop, isr_pc_flush, isr_pipe_flush} = '0;
        {branch_flush, jump_flush, mul_stall, div_running} = '0;
        {id_rs_a, id_rs_b, exe_rs_a, exe_rs_b, exe_rd, mem_rd, wb_rd} = '0;
        {exe_wr_en, mem_wr_en, wb_wr_en} = '0;
        {id_sel_opa, id_sel_opb, id_is_stype, id_sel_opbr} = '0;
        {id_imm_select, id_opcode, exe_opcode} = '0;
        {exe_comp_use_a, exe_comp_use_b, exe_is_comp} = '0;
        {exe_sel_data, mem_sel_data, wb_sel_data} = '0;
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        cycle_limit = 50;
        load_vectors();
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        // Tracked bits come straight from reset here
        @(negedge clk);
        check_outputs("reset_state", IDLE_EXP);
        for (int i = 0; i < num_vec; i++)
            apply_vector(i);
        $display("Tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && num_vec > 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
